/* build.f */
+incdir+.
ring_node_pkg.sv
phase_detector.sv
error_combiner.sv
loop_filter.sv
dco.sv
wb_cfg_regs.sv
ring_node.sv
tb_ring_node.sv

/* Makefile */
TOP = tb_ring_node

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "Simulation FAILED" sim.log; then \
		echo "Test failed"; \
		exit 1; \
	fi
	@grep -q "Simulation PASSED" sim.log

lint:
	verilator --lint-only -Wall -f build.f --top-module ring_node

clean:
	rm -rf obj_dir sim.log

/* tb_ring_node.sv */
`timescale 1ns/1ps

`include "ring_node_settings.svh"

module tb_ring_node
    import ring_node_pkg::*;
();

    localparam int ERR_LIM      = 2 ** (`RN_ERR_W - 1) - 1;
    localparam int CC_LIM       = 2 ** (`RN_CC_W - 1) - 1;
    localparam int INT_HI       = 2 ** (`RN_INT_W - 1) - 1;
    localparam int INT_LO       = -(2 ** (`RN_INT_W - 1));
    localparam int KP_MASK      = 2 ** `RN_KP_W - 1;
    localparam int KI_MASK      = 2 ** `RN_KI_W - 1;
    localparam int W_MASK       = 2 ** `RN_WEIGHT_W - 1;
    // Divided output period at control code zero, in board clock cycles
    localparam int PERIOD0      = 8 * (2 ** `RN_ACC_W) / `RN_NCO_BASE;
    localparam int WB_TIMEOUT   = 20;
    localparam int EDGE_TIMEOUT = 600;
    localparam int QUIET_CYCLES = 400;
    localparam int CLOSE_AT     = 24;
    localparam int PULSE_W      = 4;

    typedef struct packed {
        int use_above;
        int ref_offset;
        int exp_err;
    } pd_row_t;

    typedef struct packed {
        int kp;
        int ki;
        int w_left;
        int w_above;
        int w_right;
        int w_below;
        int e_right;
        int e_bottom;
        int updates;
        int check_final;
        int final_cc;
    } loop_row_t;

    logic       clk;
    logic       rst_n;
    logic       ref_left;
    logic       ref_above;
    err_t       error_right;
    err_t       error_bottom;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    logic [2:0] wb_adr;
    logic [7:0] wb_dat_w;
    logic       gen_clk;
    logic       gen_div8;
    err_t       error_left;
    err_t       error_above;
    cc_t        dco_cc;
    logic [7:0] wb_dat_r;
    logic       wb_ack;

    int mismatch_count;
    int failure_count;
    int seed;

    // Negative offsets put the reference edge before the generated edge
    pd_row_t pd_table [8] = '{
        '{0, -3, 3}, '{0, 6, -6}, '{1, -9, 9}, '{1, 2, -2},
        '{0, 0, 0}, '{1, -20, 15}, '{0, 18, -15}, '{1, 1, -1}
    };

    loop_row_t loop_table [5] = '{
        '{9, 1, 0, 0, 4, 0, 5, 0, 10, 0, 0},
        '{32, 16, 0, 0, 4, 0, -6, 0, 10, 0, 0},
        '{20, 64, 0, 0, 8, 0, 3, 0, 8, 0, 0},
        '{63, 255, 0, 0, 15, 0, 15, 0, 12, 1, 15},
        '{63, 255, 0, 0, 15, 0, -15, 0, 12, 1, -15}
    };

    logic [7:0] reg_value [7] = '{8'hA5, 8'h5C, 8'h3B, 8'hC6, 8'h7D, 8'h19, 8'hFF};
    logic [7:0] reg_mask [7]  = '{8'(KP_MASK), 8'(KI_MASK), 8'(W_MASK), 8'(W_MASK),
                                  8'(W_MASK), 8'(W_MASK), 8'h01};

    ring_node dut (
        .fpga_clk_i    (clk),
        .rst_n_i       (rst_n),
        .ref_left_i    (ref_left),
        .ref_above_i   (ref_above),
        .error_right_i (error_right),
        .error_bottom_i(error_bottom),
        .wb_cyc_i      (wb_cyc),
        .wb_stb_i      (wb_stb),
        .wb_we_i       (wb_we),
        .wb_adr_i      (wb_adr),
        .wb_dat_i      (wb_dat_w),
        .gen_clk_o     (gen_clk),
        .gen_div8_o    (gen_div8),
        .error_left_o  (error_left),
        .error_above_o (error_above),
        .dco_cc_o      (dco_cc),
        .wb_dat_o      (wb_dat_r),
        .wb_ack_o      (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_err(input string name, input err_t got, input err_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0d ns: %s got %0d, expected %0d", $time, name, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_cc(input string name, input cc_t got, input cc_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0d ns: %s got %0d, expected %0d", $time, name, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_data(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0d ns: %s got 0x%02h, expected 0x%02h",
                     $time, name, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0d ns: %s got %b, expected %b", $time, name, got, exp);
            mismatch_count++;
        end
    endtask

    function automatic int saturate(input int value, input int lo, input int hi);
        if (value > hi) begin
            return hi;
        end
        if (value < lo) begin
            return lo;
        end
        return value;
    endfunction

    // Reference detectors stay idle in these rows, so only right and below count
    function automatic int comb_model(input loop_row_t row);
        int sum;
        sum = row.w_right * row.e_right + row.w_below * row.e_bottom;
        return saturate(sum >>> `RN_COMB_SHIFT, -ERR_LIM, ERR_LIM);
    endfunction

    function automatic int filter_model(input int kp, input int ki, input int e,
                                        inout int integ);
        integ = saturate(integ + ki * e, INT_LO, INT_HI);
        return saturate(((kp * e) >>> `RN_KP_FRAC) + (integ >>> `RN_KI_FRAC),
                        -CC_LIM, CC_LIM);
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        rst_n        <= 1'b0;
        ref_left     <= 1'b0;
        ref_above    <= 1'b0;
        error_right  <= '0;
        error_bottom <= '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic wb_transfer(input logic we, input logic [2:0] adr, input logic [7:0] wdata,
                               output logic [7:0] rdata);
        bit acked;
        int n;
        acked = 1'b0;
        rdata = '0;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdata;
        for (n = 0; n < WB_TIMEOUT && !acked; n++) begin
            @(negedge clk);
            if (wb_ack) begin
                acked = 1'b1;
                rdata = wb_dat_r;
            end
        end
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        if (!acked) begin
            $display("Wishbone access to address %0d got no ack within %0d cycles",
                     adr, WB_TIMEOUT);
            failure_count++;
        end
    endtask

    task automatic wb_write(input logic [2:0] adr, input logic [7:0] data);
        logic [7:0] unused;
        wb_transfer(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [2:0] adr, output logic [7:0] data);
        wb_transfer(1'b0, adr, 8'h00, data);
    endtask

    // Returns at the falling clock edge right after gen_div8_o has risen
    task automatic wait_div8_rise(output bit ok, output int cycles);
        logic prev;
        int   n;
        ok = 1'b0;
        cycles = 1;
        @(negedge clk);
        prev = gen_div8;
        for (n = 0; n < EDGE_TIMEOUT && !ok; n++) begin
            @(negedge clk);
            cycles++;
            if (gen_div8 && !prev) begin
                ok = 1'b1;
            end
            prev = gen_div8;
        end
        if (!ok) begin
            $display("Timed out at %0d ns waiting for a rising edge of gen_div8_o", $time);
            failure_count++;
        end
    endtask

    task automatic run_pd_row(input pd_row_t row);
        bit    ok;
        int    cycles;
        int    pos;
        int    ref_at;
        int    last;
        logic  level;
        err_t  got;
        string name;
        name   = (row.use_above != 0) ? "error_above_o" : "error_left_o";
        ref_at = PERIOD0 + row.ref_offset;
        last   = PERIOD0 + ((row.ref_offset > 0) ? row.ref_offset : 0);
        wait_div8_rise(ok, cycles);
        if (!ok) begin
            return;
        end
        // An early reference pulse stops the count the generated edge started
        for (pos = 1; pos <= last + 2; pos++) begin
            @(posedge clk);
            level = ((pos >= CLOSE_AT) && (pos < CLOSE_AT + PULSE_W)) ||
                    ((pos >= ref_at) && (pos < ref_at + PULSE_W));
            if (row.use_above != 0) begin
                ref_above <= level;
            end else begin
                ref_left <= level;
            end
            @(negedge clk);
            got = (row.use_above != 0) ? error_above : error_left;
            if (pos == last + 1) begin
                check_err(name, got, err_t'(-ERR_LIM));
            end
            if (pos == last + 2) begin
                check_err(name, got, err_t'(row.exp_err));
            end
        end
        @(posedge clk);
        ref_left  <= 1'b0;
        ref_above <= 1'b0;
    endtask

    task automatic run_loop_row(input loop_row_t row, output int period);
        bit ok;
        int cycles;
        int e;
        int integ;
        int exp_cc;
        int u;
        period = 0;
        apply_reset();
        error_right  <= err_t'(row.e_right);
        error_bottom <= err_t'(row.e_bottom);
        wb_write(CFG_KP, 8'(row.kp));
        wb_write(CFG_KI, 8'(row.ki));
        wb_write(CFG_W_LEFT, 8'(row.w_left));
        wb_write(CFG_W_ABOVE, 8'(row.w_above));
        wb_write(CFG_W_RIGHT, 8'(row.w_right));
        wb_write(CFG_W_BELOW, 8'(row.w_below));
        wb_write(CFG_CTRL, 8'h01);
        integ = 0;
        e = comb_model(row);
        for (u = 0; u < row.updates; u++) begin
            wait_div8_rise(ok, cycles);
            if (!ok) begin
                return;
            end
            // The strobe follows the rise by one cycle and the code follows one cycle later
            repeat (2) @(posedge clk);
            @(negedge clk);
            exp_cc = filter_model(row.kp, row.ki, e, integ);
            check_cc("dco_cc_o", dco_cc, cc_t'(exp_cc));
        end
        check_err("error_left_o", error_left, '0);
        check_err("error_above_o", error_above, '0);
        if (row.check_final != 0) begin
            check_cc("dco_cc_o", dco_cc, cc_t'(row.final_cc));
            wait_div8_rise(ok, cycles);
            wait_div8_rise(ok, cycles);
            period = cycles;
            check_cc("dco_cc_o", dco_cc, cc_t'(row.final_cc));
        end
    endtask

    initial begin
        bit         ok;
        int         cycles;
        int         i;
        int         period;
        int         period_fast;
        int         period_slow;
        logic [7:0] rdata;
        loop_row_t  rnd_row;

        mismatch_count = 0;
        failure_count  = 0;
        seed           = 41719;
        period_fast    = 0;
        period_slow    = 0;
        rst_n          = 1'b0;
        ref_left       = 1'b0;
        ref_above      = 1'b0;
        error_right    = '0;
        error_bottom   = '0;
        wb_cyc         = 1'b0;
        wb_stb         = 1'b0;
        wb_we          = 1'b0;
        wb_adr         = '0;
        wb_dat_w       = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        @(negedge clk);
        check_bit("wb_ack_o", wb_ack, 1'b0);
        check_bit("gen_clk_o", gen_clk, 1'b0);
        check_bit("gen_div8_o", gen_div8, 1'b0);
        check_err("error_left_o", error_left, '0);
        check_err("error_above_o", error_above, '0);
        check_cc("dco_cc_o", dco_cc, '0);

        // Check the register defaults, then write and read back every address
        wb_read(CFG_KP, rdata);
        check_data("wb_dat_o", rdata, 8'(`RN_KP_DEFAULT));
        wb_read(CFG_KI, rdata);
        check_data("wb_dat_o", rdata, 8'(`RN_KI_DEFAULT));
        for (i = CFG_W_LEFT; i <= CFG_CTRL; i++) begin
            wb_read(3'(i), rdata);
            check_data("wb_dat_o", rdata, 8'h00);
        end
        for (i = 0; i < 7; i++) begin
            wb_write(3'(i), reg_value[i]);
        end
        wb_write(3'd7, 8'hFF);
        for (i = 0; i < 7; i++) begin
            wb_read(3'(i), rdata);
            check_data("wb_dat_o", rdata, reg_value[i] & reg_mask[i]);
        end
        wb_read(3'd7, rdata);
        check_data("wb_dat_o", rdata, 8'h00);

        // Disabled oscillator ignores neighbour errors
        apply_reset();
        error_right  <= err_t'(7);
        error_bottom <= err_t'(-5);
        wb_write(CFG_W_RIGHT, 8'd4);
        wb_write(CFG_W_BELOW, 8'd8);
        for (i = 0; i < QUIET_CYCLES; i++) begin
            @(negedge clk);
            check_bit("gen_clk_o", gen_clk, 1'b0);
            check_bit("gen_div8_o", gen_div8, 1'b0);
            check_cc("dco_cc_o", dco_cc, '0);
        end
        wb_write(CFG_CTRL, 8'h01);
        wait_div8_rise(ok, cycles);

        apply_reset();
        wb_write(CFG_CTRL, 8'h01);
        for (i = 0; i < 8; i++) begin
            run_pd_row(pd_table[i]);
        end

        for (i = 0; i < 5; i++) begin
            run_loop_row(loop_table[i], period);
            if (loop_table[i].check_final != 0 && loop_table[i].final_cc > 0) begin
                period_fast = period;
            end else if (loop_table[i].check_final != 0) begin
                period_slow = period;
            end
        end

        for (i = 0; i < 4; i++) begin
            rnd_row.kp          = $unsigned($random(seed)) % (KP_MASK + 1);
            rnd_row.ki          = $unsigned($random(seed)) % (KI_MASK + 1);
            rnd_row.w_left      = $unsigned($random(seed)) % (W_MASK + 1);
            rnd_row.w_above     = $unsigned($random(seed)) % (W_MASK + 1);
            rnd_row.w_right     = $unsigned($random(seed)) % (W_MASK + 1);
            rnd_row.w_below     = $unsigned($random(seed)) % (W_MASK + 1);
            rnd_row.e_right     = int'($unsigned($random(seed)) % 31) - ERR_LIM;
            rnd_row.e_bottom    = int'($unsigned($random(seed)) % 31) - ERR_LIM;
            rnd_row.updates     = 6;
            rnd_row.check_final = 0;
            rnd_row.final_cc    = 0;
            run_loop_row(rnd_row, period);
        end

        if (!(period_fast > 0 && period_fast < period_slow)) begin
            $display("Frequency steering failed: period at +15 is %0d cycles, at -15 is %0d",
                     period_fast, period_slow);
            failure_count++;
        end

        $display("Error counts: %0d mismatches, %0d other failures",
                 mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* ring_node.sv */
`timescale 1ns/1ps

module ring_node
    import ring_node_pkg::*;
(
    input  logic       fpga_clk_i,
    input  logic       rst_n_i,
    input  logic       ref_left_i,
    input  logic       ref_above_i,
    input  err_t       error_right_i,
    input  err_t       error_bottom_i,
    input  logic       wb_cyc_i,
    input  logic       wb_stb_i,
    input  logic       wb_we_i,
    input  logic [2:0] wb_adr_i,
    input  logic [7:0] wb_dat_i,
    output logic       gen_clk_o,
    output logic       gen_div8_o,
    output err_t       error_left_o,
    output err_t       error_above_o,
    output cc_t        dco_cc_o,
    output logic [7:0] wb_dat_o,
    output logic       wb_ack_o
);

    kp_t     kp;
    ki_t     ki;
    weight_t weight_left;
    weight_t weight_above;
    weight_t weight_right;
    weight_t weight_below;
    logic    osc_en;
    logic    update;
    err_t    error_comb;

    wb_cfg_regs u_cfg (
        .fpga_clk_i    (fpga_clk_i),
        .rst_n_i       (rst_n_i),
        .wb_cyc_i      (wb_cyc_i),
        .wb_stb_i      (wb_stb_i),
        .wb_we_i       (wb_we_i),
        .wb_adr_i      (wb_adr_i),
        .wb_dat_i      (wb_dat_i),
        .wb_dat_o      (wb_dat_o),
        .wb_ack_o      (wb_ack_o),
        .kp_o          (kp),
        .ki_o          (ki),
        .weight_left_o (weight_left),
        .weight_above_o(weight_above),
        .weight_right_o(weight_right),
        .weight_below_o(weight_below),
        .osc_en_o      (osc_en)
    );

    phase_detector pdet_left (
        .fpga_clk_i (fpga_clk_i),
        .rst_n_i    (rst_n_i),
        .reference_i(ref_left_i),
        .generated_i(gen_div8_o),
        .phase_err_o(error_left_o)
    );

    phase_detector pdet_above (
        .fpga_clk_i (fpga_clk_i),
        .rst_n_i    (rst_n_i),
        .reference_i(ref_above_i),
        .generated_i(gen_div8_o),
        .phase_err_o(error_above_o)
    );

    // Neighbour order follows the combiner's slot numbering
    error_combiner u_comb (
        .fpga_clk_i  (fpga_clk_i),
        .rst_n_i     (rst_n_i),
        .weight_0_i  (weight_above),
        .weight_1_i  (weight_left),
        .weight_2_i  (weight_right),
        .weight_3_i  (weight_below),
        .error_0_i   (error_above_o),
        .error_1_i   (error_left_o),
        .error_2_i   (error_right_i),
        .error_3_i   (error_bottom_i),
        .error_comb_o(error_comb)
    );

    loop_filter u_filter (
        .fpga_clk_i(fpga_clk_i),
        .rst_n_i   (rst_n_i),
        .update_i  (update),
        .error_i   (error_comb),
        .kp_i      (kp),
        .ki_i      (ki),
        .dco_cc_o  (dco_cc_o)
    );

    dco u_dco (
        .fpga_clk_i(fpga_clk_i),
        .rst_n_i   (rst_n_i),
        .enable_i  (osc_en),
        .cc_i      (dco_cc_o),
        .gen_clk_o (gen_clk_o),
        .gen_div8_o(gen_div8_o),
        .update_o  (update)
    );

endmodule

/* wb_cfg_regs.sv */
`timescale 1ns/1ps

`include "ring_node_settings.svh"

module wb_cfg_regs
    import ring_node_pkg::*;
(
    input  logic       fpga_clk_i,
    input  logic       rst_n_i,
    input  logic       wb_cyc_i,
    input  logic       wb_stb_i,
    input  logic       wb_we_i,
    input  logic [2:0] wb_adr_i,
    input  logic [7:0] wb_dat_i,
    output logic [7:0] wb_dat_o,
    output logic       wb_ack_o,
    output kp_t        kp_o,
    output ki_t        ki_o,
    output weight_t    weight_left_o,
    output weight_t    weight_above_o,
    output weight_t    weight_right_o,
    output weight_t    weight_below_o,
    output logic       osc_en_o
);

    logic       req_new;
    logic [7:0] rd_data;

    // Ack is a single pulse per request, so a held request is not taken twice
    assign req_new = wb_cyc_i & wb_stb_i & ~wb_ack_o;

    always_comb begin
        case (cfg_addr_e'(wb_adr_i))
            CFG_KP:      rd_data = 8'(kp_o);
            CFG_KI:      rd_data = 8'(ki_o);
            CFG_W_LEFT:  rd_data = 8'(weight_left_o);
            CFG_W_ABOVE: rd_data = 8'(weight_above_o);
            CFG_W_RIGHT: rd_data = 8'(weight_right_o);
            CFG_W_BELOW: rd_data = 8'(weight_below_o);
            CFG_CTRL:    rd_data = {7'd0, osc_en_o};
            default:     rd_data = 8'd0;
        endcase
    end

    always_ff @(posedge fpga_clk_i) begin
        if (!rst_n_i) begin
            wb_ack_o       <= 1'b0;
            kp_o           <= kp_t'(`RN_KP_DEFAULT);
            ki_o           <= ki_t'(`RN_KI_DEFAULT);
            weight_left_o  <= '0;
            weight_above_o <= '0;
            weight_right_o <= '0;
            weight_below_o <= '0;
            osc_en_o       <= 1'b0;
        end else begin
            wb_ack_o <= req_new;
            if (req_new && wb_we_i) begin
                case (cfg_addr_e'(wb_adr_i))
                    CFG_KP:      kp_o           <= wb_dat_i[`RN_KP_W-1:0];
                    CFG_KI:      ki_o           <= wb_dat_i[`RN_KI_W-1:0];
                    CFG_W_LEFT:  weight_left_o  <= wb_dat_i[`RN_WEIGHT_W-1:0];
                    CFG_W_ABOVE: weight_above_o <= wb_dat_i[`RN_WEIGHT_W-1:0];
                    CFG_W_RIGHT: weight_right_o <= wb_dat_i[`RN_WEIGHT_W-1:0];
                    CFG_W_BELOW: weight_below_o <= wb_dat_i[`RN_WEIGHT_W-1:0];
                    CFG_CTRL:    osc_en_o       <= wb_dat_i[0];
                    default:     ;
                endcase
            end
        end
    end

    always_ff @(posedge fpga_clk_i) begin
        if (req_new) begin
            wb_dat_o <= rd_data;
        end
    end

    a_ack_follows_req: assert property (
        @(posedge fpga_clk_i) disable iff (!rst_n_i)
        wb_ack_o |-> $past(wb_cyc_i && wb_stb_i)
    );

endmodule

/* dco.sv */
`timescale 1ns/1ps

`include "ring_node_settings.svh"

module dco
    import ring_node_pkg::*;
(
    input  logic fpga_clk_i,
    input  logic rst_n_i,
    input  logic enable_i,
    input  cc_t  cc_i,
    output logic gen_clk_o,
    output logic gen_div8_o,
    output logic update_o
);

    logic [`RN_ACC_W-1:0] acc;
    logic [`RN_ACC_W-1:0] acc_inc;
    logic                 clk_q;
    logic                 clk_rise;
    logic [1:0]           div_cnt;
    logic                 div8_d;

    // Increment grows with the control code, so a positive code runs faster
    assign acc_inc = `RN_ACC_W'(`RN_NCO_BASE + `RN_NCO_STEP * int'(cc_i));

    assign gen_clk_o = acc[`RN_ACC_W-1];
    assign clk_rise  = gen_clk_o & ~clk_q;

    always_ff @(posedge fpga_clk_i) begin
        if (!rst_n_i || !enable_i) begin
            acc        <= '0;
            clk_q      <= 1'b0;
            div_cnt    <= '0;
            gen_div8_o <= 1'b0;
            div8_d     <= 1'b0;
            update_o   <= 1'b0;
        end else begin
            acc   <= acc + acc_inc;
            clk_q <= gen_clk_o;
            if (clk_rise) begin
                div_cnt <= div_cnt + 1'b1;
                if (div_cnt == 2'd3) begin
                    gen_div8_o <= ~gen_div8_o;
                end
            end
            div8_d   <= gen_div8_o;
            // Strobe lands one cycle after the divided output rises
            update_o <= gen_div8_o & ~div8_d;
        end
    end

    a_update_single: assert property (
        @(posedge fpga_clk_i) disable iff (!rst_n_i) update_o |=> !update_o
    );

endmodule

/* loop_filter.sv */
`timescale 1ns/1ps

`include "ring_node_settings.svh"

module loop_filter
    import ring_node_pkg::*;
(
    input  logic fpga_clk_i,
    input  logic rst_n_i,
    input  logic update_i,
    input  err_t error_i,
    input  kp_t  kp_i,
    input  ki_t  ki_i,
    output cc_t  dco_cc_o
);

    localparam int CC_MAX  = 2 ** (`RN_CC_W - 1) - 1;
    localparam int INT_MAX = 2 ** (`RN_INT_W - 1) - 1;
    localparam int INT_MIN = -(2 ** (`RN_INT_W - 1));

    logic signed [`RN_INT_W-1:0]            integ;
    logic signed [`RN_INT_W-1:0]            integ_next;
    logic signed [`RN_INT_W:0]              integ_sum;
    logic signed [`RN_KI_W+`RN_ERR_W:0]     ki_prod;
    logic signed [`RN_KP_W+`RN_ERR_W:0]     kp_prod;
    logic signed [`RN_INT_W:0]              cc_sum;
    cc_t                                    cc_sat;

    always_comb begin
        ki_prod   = $signed({1'b0, ki_i}) * error_i;
        kp_prod   = $signed({1'b0, kp_i}) * error_i;
        integ_sum = integ + ki_prod;

        if (integ_sum > INT_MAX) begin
            integ_next = INT_MAX[`RN_INT_W-1:0];
        end else if (integ_sum < INT_MIN) begin
            integ_next = INT_MIN[`RN_INT_W-1:0];
        end else begin
            integ_next = integ_sum[`RN_INT_W-1:0];
        end

        // The output already sees the integrator value of this update
        cc_sum = (kp_prod >>> `RN_KP_FRAC) + (integ_next >>> `RN_KI_FRAC);

        if (cc_sum > CC_MAX) begin
            cc_sat = cc_t'(CC_MAX);
        end else if (cc_sum < -CC_MAX) begin
            cc_sat = cc_t'(-CC_MAX);
        end else begin
            cc_sat = cc_sum[`RN_CC_W-1:0];
        end
    end

    always_ff @(posedge fpga_clk_i) begin
        if (!rst_n_i) begin
            integ    <= '0;
            dco_cc_o <= '0;
        end else if (update_i) begin
            integ    <= integ_next;
            dco_cc_o <= cc_sat;
        end
    end

    // The most negative code is never produced, so the range stays symmetric
    a_cc_range: assert property (
        @(posedge fpga_clk_i) disable iff (!rst_n_i)
        (dco_cc_o >= -CC_MAX) && (dco_cc_o <= CC_MAX)
    );

endmodule

/* error_combiner.sv */
`timescale 1ns/1ps

`include "ring_node_settings.svh"

module error_combiner
    import ring_node_pkg::*;
(
    input  logic    fpga_clk_i,
    input  logic    rst_n_i,
    input  weight_t weight_0_i,
    input  weight_t weight_1_i,
    input  weight_t weight_2_i,
    input  weight_t weight_3_i,
    input  err_t    error_0_i,
    input  err_t    error_1_i,
    input  err_t    error_2_i,
    input  err_t    error_3_i,
    output err_t    error_comb_o
);

    localparam int PROD_W  = `RN_WEIGHT_W + `RN_ERR_W + 1;
    localparam int SUM_W   = PROD_W + 2;
    localparam int ERR_MAX = 2 ** (`RN_ERR_W - 1) - 1;

    weight_t weight [4];
    err_t    error [4];
    logic signed [PROD_W-1:0] prod [4];
    logic signed [SUM_W-1:0]  sum;
    logic signed [SUM_W-1:0]  scaled;
    err_t                     comb_sat;

    assign weight = '{weight_0_i, weight_1_i, weight_2_i, weight_3_i};
    assign error  = '{error_0_i, error_1_i, error_2_i, error_3_i};

    always_comb begin
        sum = '0;
        for (int i = 0; i < 4; i++) begin
            // Weights are unsigned, so widen them with a zero sign bit
            prod[i] = $signed({1'b0, weight[i]}) * error[i];
            sum     = sum + prod[i];
        end
        scaled = sum >>> `RN_COMB_SHIFT;

        if (scaled > ERR_MAX) begin
            comb_sat = err_t'(ERR_MAX);
        end else if (scaled < -ERR_MAX) begin
            comb_sat = err_t'(-ERR_MAX);
        end else begin
            comb_sat = scaled[`RN_ERR_W-1:0];
        end
    end

    always_ff @(posedge fpga_clk_i) begin
        if (!rst_n_i) begin
            error_comb_o <= '0;
        end else begin
            error_comb_o <= comb_sat;
        end
    end

endmodule

/* phase_detector.sv */
`timescale 1ns/1ps

`include "ring_node_settings.svh"

module phase_detector
    import ring_node_pkg::*;
(
    input  logic fpga_clk_i,
    input  logic rst_n_i,
    input  logic reference_i,
    input  logic generated_i,
    output err_t phase_err_o
);

    localparam int CNT_MAX = 2 ** (`RN_ERR_W - 1) - 1;

    logic ref_q;
    logic ref_d;
    logic gen_q;
    logic gen_d;
    logic ref_rise;
    logic gen_rise;
    logic active;
    logic ref_first;
    logic [`RN_ERR_W-1:0] count;
    logic [`RN_ERR_W-1:0] count_inc;

    assign ref_rise = ref_q & ~ref_d;
    assign gen_rise = gen_q & ~gen_d;

    assign count_inc = (count == CNT_MAX) ? count : count + 1'b1;

    always_ff @(posedge fpga_clk_i) begin
        if (!rst_n_i) begin
            ref_q       <= 1'b0;
            ref_d       <= 1'b0;
            gen_q       <= 1'b0;
            gen_d       <= 1'b0;
            active      <= 1'b0;
            ref_first   <= 1'b0;
            count       <= '0;
            phase_err_o <= '0;
        end else begin
            ref_q <= reference_i;
            ref_d <= ref_q;
            gen_q <= generated_i;
            gen_d <= gen_q;

            if (ref_rise && gen_rise) begin
                // Coincident edges are in phase
                active      <= 1'b0;
                count       <= '0;
                phase_err_o <= '0;
            end else if (ref_rise || gen_rise) begin
                if (active && (ref_rise != ref_first)) begin
                    active      <= 1'b0;
                    phase_err_o <= ref_first ? err_t'(count) : -err_t'(count);
                end else begin
                    // A first edge or a repeated edge on the same input restarts the count
                    active    <= 1'b1;
                    ref_first <= ref_rise;
                    count     <= 1;
                end
            end else if (active) begin
                count <= count_inc;
            end
        end
    end

    a_count_limit: assert property (
        @(posedge fpga_clk_i) disable iff (!rst_n_i) count <= CNT_MAX
    );

endmodule

/* ring_node_pkg.sv */
`include "ring_node_settings.svh"

package ring_node_pkg;

    // Phase errors are counted in board clock cycles
    typedef logic signed [`RN_ERR_W-1:0] err_t;

    // Control code of the oscillator where a positive code runs faster
    typedef logic signed [`RN_CC_W-1:0] cc_t;

    typedef logic [`RN_WEIGHT_W-1:0] weight_t;

    typedef logic [`RN_KP_W-1:0] kp_t;
    typedef logic [`RN_KI_W-1:0] ki_t;

    // Word addresses of the configuration slave
    typedef enum logic [2:0] {
        CFG_KP      = 3'd0,
        CFG_KI      = 3'd1,
        CFG_W_LEFT  = 3'd2,
        CFG_W_ABOVE = 3'd3,
        CFG_W_RIGHT = 3'd4,
        CFG_W_BELOW = 3'd5,
        CFG_CTRL    = 3'd6
    } cfg_addr_e;

endpackage

/* ring_node_settings.svh */
`ifndef RING_NODE_SETTINGS_SVH
`define RING_NODE_SETTINGS_SVH

// Datapath widths
`define RN_ERR_W        5
`define RN_CC_W         5
`define RN_WEIGHT_W     4

// Loop filter gains in unsigned fixed point
`define RN_KP_W         6
`define RN_KP_FRAC      5
`define RN_KI_W         8
`define RN_KI_FRAC      7
`define RN_INT_W        16
`define RN_KP_DEFAULT   9
`define RN_KI_DEFAULT   1

// A weight of 4 is unity in the combiner
`define RN_COMB_SHIFT   2

// At code 0 the oscillator's gen_clk runs at 1/16 of the board clock
`define RN_ACC_W        16
`define RN_NCO_BASE     4096
`define RN_NCO_STEP     128

`endif
